/* design/capture_pkg.sv */
package capture_pkg;

  import rx_pkg::*;

  // digital trigger lines
  localparam int n_trig = 2;

  // frames held by the sample buffer
  localparam int buffer_depth = 64;
  localparam int addr_width = $clog2(buffer_depth);

  // frame count, 0 to buffer_depth inclusive
  typedef logic [addr_width:0] count_t;

  // buffer address
  typedef logic [addr_width-1:0] addr_t;

  // cycles since arm
  typedef logic [15:0] tstamp_t;

  // trigger lines and their enable mask
  typedef logic [n_trig-1:0] trig_t;

  typedef enum logic [1:0] {
    idle,
    armed,
    capturing
  } capture_state_e;

  // buffer entry
  typedef struct packed {
    sample_frame_t frame;
    tstamp_t       tstamp;
  } stored_frame_t;

  // one readout beat, no back-pressure
  typedef struct packed {
    sample_vec_t samples;
    keep_mask_t  keep;
    tstamp_t     tstamp;
    logic        valid;
    logic        last;
  } readout_beat_t;

endpackage

/* design/capture_trigger.sv */
`timescale 1ns/1ps

module capture_trigger
  import rx_pkg::*;
  import capture_pkg::*;
(
  input  logic           ps_clk,
  input  logic           capture_reset,
  input  sample_frame_t  frame_i,
  input  trig_t          trig_i,
  input  trig_t          trig_mask_i,
  input  logic           arm_i,
  input  logic           stop_i,
  input  logic           capture_sw_reset_i,
  output logic           wr_en_o,
  output stored_frame_t  wr_frame_o,
  output capture_state_e state_o
);

  capture_state_e state_q;
  capture_state_e state_d;
  tstamp_t        tstamp_q;
  logic           trig_hit;
  logic           arm_accept;

  // any enabled trigger line high
  assign trig_hit   = |(trig_i & trig_mask_i);
  assign arm_accept = (state_q == idle) && arm_i;

  // stop and sw reset win over everything else
  always_comb begin
    state_d = state_q;
    if (stop_i || capture_sw_reset_i) begin
      state_d = idle;
    end else begin
      case (state_q)
        idle:      if (arm_i) state_d = armed;
        armed:     if (trig_hit) state_d = capturing;
        capturing: state_d = capturing;
        default:   state_d = idle;
      endcase
    end
  end

  // state, timestamp and write strobe
  always_ff @(posedge ps_clk) begin
    if (!capture_reset) begin
      state_q  <= idle;
      tstamp_q <= '0;
      wr_en_o  <= 1'b0;
    end else begin
      state_q  <= state_d;
      // cleared when the arm is taken, free running otherwise
      tstamp_q <= arm_accept ? '0 : tstamp_q + tstamp_t'(1);
      wr_en_o  <= (state_q == capturing) && frame_i.valid && (|frame_i.keep);
    end
  end

  // frame and its timestamp, qualified by wr_en_o
  always_ff @(posedge ps_clk) begin
    wr_frame_o.frame  <= frame_i;
    wr_frame_o.tstamp <= tstamp_q;
  end

  assign state_o = state_q;

endmodule

/* design/receive_top.sv */
`timescale 1ns/1ps

module receive_top
  import rx_pkg::*;
  import capture_pkg::*;
(
  input  logic           ps_clk,
  input  logic           capture_reset,
  // adc samples
  input  sample_vec_t    adc_data_i,
  input  logic           adc_valid_i,
  // configuration levels
  input  mux_sel_vec_t   mux_sel_i,
  input  sample_vec_t    threshold_i,
  input  hold_t          hold_i,
  input  trig_t          trig_mask_i,
  // digital triggers
  input  trig_t          trig_i,
  // command pulses
  input  logic           arm_i,
  input  logic           stop_i,
  input  logic           capture_sw_reset_i,
  input  logic           readout_start_i,
  input  logic           readout_sw_reset_i,
  // status and readout
  output count_t         write_count_o,
  output logic           buffer_full_o,
  output capture_state_e state_o,
  output readout_beat_t  readout_o
);

  sample_frame_t mux_frame;
  sample_frame_t disc_frame;
  logic          wr_en;
  stored_frame_t wr_frame;

  // stage 1, raw or differenced source per channel
  rx_channel_mux mux0 (
    .ps_clk        (ps_clk),
    .capture_reset (capture_reset),
    .adc_data_i    (adc_data_i),
    .adc_valid_i   (adc_valid_i),
    .mux_sel_i     (mux_sel_i),
    .frame_o       (mux_frame)
  );

  // stage 2, threshold and hold
  sample_discriminator disc0 (
    .ps_clk        (ps_clk),
    .capture_reset (capture_reset),
    .frame_i       (mux_frame),
    .threshold_i   (threshold_i),
    .hold_i        (hold_i),
    .frame_o       (disc_frame)
  );

  // stage 3, arm and trigger gating, timestamps
  capture_trigger trig0 (
    .ps_clk             (ps_clk),
    .capture_reset      (capture_reset),
    .frame_i            (disc_frame),
    .trig_i             (trig_i),
    .trig_mask_i        (trig_mask_i),
    .arm_i              (arm_i),
    .stop_i             (stop_i),
    .capture_sw_reset_i (capture_sw_reset_i),
    .wr_en_o            (wr_en),
    .wr_frame_o         (wr_frame),
    .state_o            (state_o)
  );

  // stage 4, frame storage and readout
  sample_buffer buf0 (
    .ps_clk             (ps_clk),
    .capture_reset      (capture_reset),
    .wr_en_i            (wr_en),
    .wr_frame_i         (wr_frame),
    .capture_sw_reset_i (capture_sw_reset_i),
    .readout_start_i    (readout_start_i),
    .readout_sw_reset_i (readout_sw_reset_i),
    .write_count_o      (write_count_o),
    .buffer_full_o      (buffer_full_o),
    .readout_o          (readout_o)
  );

endmodule

/* design/rx_channel_mux.sv */
`timescale 1ns/1ps

module rx_channel_mux
  import rx_pkg::*;
(
  input  logic          ps_clk,
  input  logic          capture_reset,
  input  sample_vec_t   adc_data_i,
  input  logic          adc_valid_i,
  input  mux_sel_vec_t  mux_sel_i,
  output sample_frame_t frame_o
);

  // last valid raw sample of each channel
  sample_vec_t prev_q;
  // current minus previous, wraps at 16 bits
  sample_vec_t diff;
  // registered mux outputs
  sample_vec_t samples_q;
  logic        valid_q;

  // previous sample only moves on valid input
  // starts from zero so the first difference is the sample itself
  always_ff @(posedge ps_clk) begin
    if (!capture_reset) begin
      prev_q <= '0;
    end else if (adc_valid_i) begin
      prev_q <= adc_data_i;
    end
  end

  always_comb begin
    for (int ch = 0; ch < n_channels; ch++) begin
      diff[ch] = adc_data_i[ch] - prev_q[ch];
    end
  end

  // per output channel source select
  // bit 2 of the select picks the difference path
  always_ff @(posedge ps_clk) begin
    for (int ch = 0; ch < n_channels; ch++) begin
      if (mux_sel_i[ch][2]) begin
        samples_q[ch] <= diff[mux_sel_i[ch][1:0]];
      end else begin
        samples_q[ch] <= adc_data_i[mux_sel_i[ch][1:0]];
      end
    end
  end

  // valid follows the samples by one cycle
  always_ff @(posedge ps_clk) begin
    if (!capture_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= adc_valid_i;
    end
  end

  // keep is decided downstream
  always_comb begin
    frame_o.samples = samples_q;
    frame_o.valid   = valid_q;
    frame_o.keep    = '0;
  end

endmodule

/* design/rx_pkg.sv */
package rx_pkg;

  // adc channel count
  localparam int n_channels = 4;

  // bits per adc sample
  localparam int sample_width = 16;

  // hold counter width, up to 15 cycles
  localparam int hold_width = 4;

  // signed two's complement adc sample
  typedef logic signed [sample_width-1:0] sample_t;

  // source select per output channel
  // 0..3 raw channel, 4..7 first difference of channel (sel - 4)
  typedef logic [2:0] mux_sel_t;

  // one keep bit per channel
  typedef logic [n_channels-1:0] keep_mask_t;

  // discriminator hold length in samples
  typedef logic [hold_width-1:0] hold_t;

  // one sample per channel, channel 0 in the low bits
  typedef sample_t [n_channels-1:0] sample_vec_t;

  // one select per output channel
  typedef mux_sel_t [n_channels-1:0] mux_sel_vec_t;

  // frame moving between the signal path stages, 69 bits
  typedef struct packed {
    sample_vec_t samples;
    logic        valid;
    keep_mask_t  keep;
  } sample_frame_t;

endpackage

/* design/sample_buffer.sv */
`timescale 1ns/1ps

module sample_buffer
  import rx_pkg::*;
  import capture_pkg::*;
(
  input  logic          ps_clk,
  input  logic          capture_reset,
  input  logic          wr_en_i,
  input  stored_frame_t wr_frame_i,
  input  logic          capture_sw_reset_i,
  input  logic          readout_start_i,
  input  logic          readout_sw_reset_i,
  output count_t        write_count_o,
  output logic          buffer_full_o,
  output readout_beat_t readout_o
);

  stored_frame_t mem [buffer_depth];

  // write pointer doubles as frame count
  count_t        wr_ptr_q;
  logic          full;
  // read side
  logic          reading_q;
  addr_t         rd_ptr_q;
  addr_t         rd_last_q;
  count_t        last_idx;
  stored_frame_t rd_data_q;
  logic          rd_valid_q;
  logic          rd_is_last_q;
  logic          start_ok;

  assign full     = (wr_ptr_q == count_t'(buffer_depth));
  assign last_idx = wr_ptr_q - count_t'(1);
  // no restart while beats are still going out or nothing is stored
  assign start_ok = readout_start_i && !reading_q && !rd_valid_q && (wr_ptr_q != '0);

  // writes stop once full
  always_ff @(posedge ps_clk) begin
    if (wr_en_i && !full) begin
      mem[wr_ptr_q[addr_width-1:0]] <= wr_frame_i;
    end
  end

  always_ff @(posedge ps_clk) begin
    if (!capture_reset || capture_sw_reset_i) begin
      wr_ptr_q <= '0;
    end else if (wr_en_i && !full) begin
      wr_ptr_q <= wr_ptr_q + count_t'(1);
    end
  end

  // readout sequencer
  // start -> address issue next cycle -> beat the cycle after
  always_ff @(posedge ps_clk) begin
    if (!capture_reset || readout_sw_reset_i) begin
      reading_q    <= 1'b0;
      rd_ptr_q     <= '0;
      rd_last_q    <= '0;
      rd_valid_q   <= 1'b0;
      rd_is_last_q <= 1'b0;
    end else begin
      rd_valid_q   <= reading_q;
      rd_is_last_q <= reading_q && (rd_ptr_q == rd_last_q);
      if (start_ok) begin
        reading_q <= 1'b1;
        rd_ptr_q  <= '0;
        // frame count is latched at the start
        rd_last_q <= last_idx[addr_width-1:0];
      end else if (reading_q) begin
        rd_ptr_q <= rd_ptr_q + addr_t'(1);
        if (rd_ptr_q == rd_last_q) begin
          reading_q <= 1'b0;
        end
      end
    end
  end

  // registered memory read
  always_ff @(posedge ps_clk) begin
    rd_data_q <= mem[rd_ptr_q];
  end

  always_comb begin
    readout_o.samples = rd_data_q.frame.samples;
    readout_o.keep    = rd_data_q.frame.keep;
    readout_o.tstamp  = rd_data_q.tstamp;
    readout_o.valid   = rd_valid_q;
    readout_o.last    = rd_is_last_q;
  end

  assign write_count_o = wr_ptr_q;
  assign buffer_full_o = full;

endmodule

/* design/sample_discriminator.sv */
`timescale 1ns/1ps

module sample_discriminator
  import rx_pkg::*;
(
  input  logic          ps_clk,
  input  logic          capture_reset,
  input  sample_frame_t frame_i,
  input  sample_vec_t   threshold_i,
  input  hold_t         hold_i,
  output sample_frame_t frame_o
);

  // remaining hold samples per channel
  hold_t hold_cnt_q [n_channels];
  hold_t hold_cnt_d [n_channels];

  keep_mask_t keep_d;
  keep_mask_t keep_q;
  sample_vec_t samples_q;
  logic        valid_q;

  // threshold and hold decision per channel
  always_comb begin
    for (int ch = 0; ch < n_channels; ch++) begin
      keep_d[ch]     = 1'b0;
      hold_cnt_d[ch] = hold_cnt_q[ch];
      if (frame_i.valid) begin
        if ($signed(frame_i.samples[ch]) >= $signed(threshold_i[ch])) begin
          // at or above threshold, restart the hold window
          keep_d[ch]     = 1'b1;
          hold_cnt_d[ch] = hold_i;
        end else if (hold_cnt_q[ch] != '0) begin
          // below threshold but still inside the hold window
          keep_d[ch]     = 1'b1;
          hold_cnt_d[ch] = hold_cnt_q[ch] - hold_t'(1);
        end
      end
    end
  end

  // hold counters, keep and valid
  always_ff @(posedge ps_clk) begin
    if (!capture_reset) begin
      for (int ch = 0; ch < n_channels; ch++) begin
        hold_cnt_q[ch] <= '0;
      end
      keep_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      for (int ch = 0; ch < n_channels; ch++) begin
        hold_cnt_q[ch] <= hold_cnt_d[ch];
      end
      keep_q  <= keep_d;
      valid_q <= frame_i.valid;
    end
  end

  // samples pass through unchanged
  always_ff @(posedge ps_clk) begin
    samples_q <= frame_i.samples;
  end

  always_comb begin
    frame_o.samples = samples_q;
    frame_o.valid   = valid_q;
    frame_o.keep    = keep_q;
  end

endmodule

/* list.f */
design/rx_pkg.sv
design/capture_pkg.sv
design/rx_channel_mux.sv
design/sample_discriminator.sv
design/capture_trigger.sv
design/sample_buffer.sv
design/receive_top.sv
verif/receive_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the receive path testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module receive_top_tb -Mdir obj_dir -o receive_top_tb_sim -f list.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/receive_top_tb_sim > "$log" 2>&1
run_status=$?
cat "$log"

# the log decides the result
if grep -q "Verification failed" "$log"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "Verification passed" "$log"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

/* verif/receive_top_tb.sv */
`timescale 1ns/1ps

module receive_top_tb
  import rx_pkg::*;
  import capture_pkg::*;
();

  // whole sequence is well under 1000 cycles
  localparam int max_cycles = 6000;
  // triangle half swing around the per channel dc offset
  localparam int wave_amp = 3000;

  // one expected buffer entry
  typedef struct packed {
    sample_vec_t samples;
    keep_mask_t  keep;
  } exp_frame_t;

  logic           ps_clk;
  logic           capture_reset;
  sample_vec_t    adc_data_i;
  logic           adc_valid_i;
  mux_sel_vec_t   mux_sel_i;
  sample_vec_t    threshold_i;
  hold_t          hold_i;
  trig_t          trig_mask_i;
  trig_t          trig_i;
  logic           arm_i;
  logic           stop_i;
  logic           capture_sw_reset_i;
  logic           readout_start_i;
  logic           readout_sw_reset_i;
  count_t         write_count_o;
  logic           buffer_full_o;
  capture_state_e state_o;
  readout_beat_t  readout_o;

  // reference model state
  sample_vec_t m_prev;
  hold_t       m_hold [n_channels];
  exp_frame_t  exp_q [$];
  logic        in_window;
  logic        quiet;
  int          sample_n;
  int          phase [n_channels];
  int          dc [n_channels];
  // readout tracking
  int          rd_idx;
  int          rd_total;
  tstamp_t     prev_ts;
  int          cycle_cnt = 0;
  int          err_cnt = 0;

  receive_top dut0 (.*);

  initial begin
    ps_clk = 1'b0;
    forever #2 ps_clk = ~ps_clk;
  end

  task automatic abort_on_hang(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    err_cnt++;
    $display("ERR %0t %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  // run limit
  always @(posedge ps_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      abort_on_hang($sformatf("run did not finish within %0d cycles", max_cycles));
    end
  end

  // triangle of period 16 + 8*ch samples per channel
  function automatic sample_t wave_value(input int ch, input int n);
    int period;
    int half;
    int pos;
    int v;
    period = 16 + 8 * ch;
    half   = period / 2;
    pos    = (n + phase[ch]) % period;
    if (pos < half) begin
      v = -wave_amp + pos * (2 * wave_amp / half);
    end else begin
      v = wave_amp - (pos - half) * (2 * wave_amp / half);
    end
    return sample_t'(v + dc[ch]);
  endfunction

  // mux, difference and hold rules applied to one presented sample
  task automatic model_step(input sample_vec_t din, input logic vld);
    exp_frame_t f;
    logic [1:0] idx;
    for (int ch = 0; ch < n_channels; ch++) begin
      idx = mux_sel_i[ch][1:0];
      if (mux_sel_i[ch][2]) begin
        f.samples[ch] = din[idx] - m_prev[idx];
      end else begin
        f.samples[ch] = din[idx];
      end
    end
    f.keep = '0;
    // invalid samples leave hold and previous value alone
    if (vld) begin
      for (int ch = 0; ch < n_channels; ch++) begin
        if ($signed(f.samples[ch]) >= $signed(threshold_i[ch])) begin
          f.keep[ch] = 1'b1;
          m_hold[ch] = hold_i;
        end else if (m_hold[ch] != '0) begin
          f.keep[ch] = 1'b1;
          m_hold[ch] = m_hold[ch] - hold_t'(1);
        end
      end
      m_prev = din;
      if (in_window && f.keep != '0) begin
        exp_q.push_back(f);
      end
    end
  endtask

  task automatic drive_sample();
    sample_vec_t din;
    logic        vld;
    if (quiet) begin
      din = '0;
      vld = 1'b1;
    end else begin
      for (int ch = 0; ch < n_channels; ch++) begin
        din[ch] = wave_value(ch, sample_n);
      end
      // occasional gap in the adc stream
      vld = ($urandom_range(0, 7) != 0);
    end
    adc_data_i  = din;
    adc_valid_i = vld;
    model_step(din, vld);
    sample_n++;
  endtask

  task automatic check_beat();
    exp_frame_t e;
    assert (rd_idx < rd_total)
      else report_mismatch($sformatf("beat %0d beyond %0d stored frames", rd_idx, rd_total));
    assert (readout_o.keep != '0)
      else report_mismatch($sformatf("beat %0d stored with empty keep mask", rd_idx));
    e = exp_q[rd_idx];
    assert (readout_o.samples == e.samples)
      else report_mismatch($sformatf("beat %0d samples %h, expected %h",
                                     rd_idx, readout_o.samples, e.samples));
    assert (readout_o.keep == e.keep)
      else report_mismatch($sformatf("beat %0d keep %b, expected %b",
                                     rd_idx, readout_o.keep, e.keep));
    // at or above threshold is always kept, below only through hold
    for (int ch = 0; ch < n_channels; ch++) begin
      if ($signed(readout_o.samples[ch]) >= $signed(threshold_i[ch])) begin
        assert (readout_o.keep[ch])
          else report_mismatch($sformatf("beat %0d ch %0d over threshold not kept", rd_idx, ch));
      end else if (hold_i == '0) begin
        assert (!readout_o.keep[ch])
          else report_mismatch($sformatf("beat %0d ch %0d kept below threshold", rd_idx, ch));
      end
    end
    assert (readout_o.last == (rd_idx == rd_total - 1))
      else report_mismatch($sformatf("beat %0d last flag %b", rd_idx, readout_o.last));
    if (rd_idx > 0) begin
      assert (readout_o.tstamp > prev_ts)
        else report_mismatch($sformatf("beat %0d tstamp %0d not above %0d",
                                       rd_idx, readout_o.tstamp, prev_ts));
    end
    prev_ts = readout_o.tstamp;
    rd_idx++;
  endtask

  // check the beat, drop the pulses and present the next sample each clock
  task automatic tick();
    @(posedge ps_clk);
    #1;
    if (readout_o.valid) begin
      check_beat();
    end
    arm_i              = 1'b0;
    stop_i             = 1'b0;
    capture_sw_reset_i = 1'b0;
    readout_start_i    = 1'b0;
    readout_sw_reset_i = 1'b0;
    drive_sample();
  endtask

  task automatic run(input int n);
    repeat (n) tick();
  endtask

  // sel lists out3 down to out0
  // raw picks get a level threshold and differences a slope one
  task automatic set_mux(input mux_sel_vec_t sel);
    mux_sel_i = sel;
    for (int ch = 0; ch < n_channels; ch++) begin
      threshold_i[ch] = sel[ch][2] ? 16'sd200 : 16'sd1000;
    end
  endtask

  // quiet stretch on both sides of the trigger
  task automatic fire_trigger();
    quiet = 1'b1;
    run(10);
    trig_i    = 2'b01;
    in_window = 1'b1;
    run(2);
    trig_i = '0;
    run(10);
    quiet = 1'b0;
  endtask

  task automatic end_capture();
    quiet = 1'b1;
    run(10);
    stop_i    = 1'b1;
    in_window = 1'b0;
    run(10);
    quiet = 1'b0;
  endtask

  task automatic clear_and_arm();
    capture_sw_reset_i = 1'b1;
    exp_q.delete();
    tick();
    arm_i = 1'b1;
    tick();
  endtask

  task automatic start_readout();
    int exp_n;
    exp_n = (exp_q.size() > buffer_depth) ? buffer_depth : exp_q.size();
    assert (write_count_o == count_t'(exp_n))
      else report_mismatch($sformatf("write count %0d, expected %0d", write_count_o, exp_n));
    rd_total        = exp_n;
    rd_idx          = 0;
    readout_start_i = 1'b1;
  endtask

  task automatic wait_beats(input int n);
    int guard;
    guard = 0;
    while (rd_idx < n) begin
      if (guard > n + 8) begin
        abort_on_hang("readout stalled before the expected beats arrived");
      end
      tick();
      guard++;
    end
  endtask

  task automatic read_all();
    start_readout();
    wait_beats(rd_total);
    run(4);
    assert (!readout_o.valid) else report_mismatch("readout valid after the last beat");
  endtask

  initial begin
    int aborted_at;
    void'($urandom(32'h7e22));
    capture_reset      = 1'b0;
    adc_data_i         = '0;
    adc_valid_i        = 1'b0;
    hold_i             = '0;
    trig_mask_i        = 2'b01;
    trig_i             = '0;
    arm_i              = 1'b0;
    stop_i             = 1'b0;
    capture_sw_reset_i = 1'b0;
    readout_start_i    = 1'b0;
    readout_sw_reset_i = 1'b0;
    set_mux({3'd3, 3'd2, 3'd1, 3'd0});
    m_prev    = '0;
    in_window = 1'b0;
    quiet     = 1'b1;
    sample_n  = 0;
    rd_idx    = 0;
    rd_total  = 0;
    prev_ts   = '0;
    for (int ch = 0; ch < n_channels; ch++) begin
      m_hold[ch] = '0;
      phase[ch]  = int'($urandom_range(0, 63));
      dc[ch]     = int'($urandom_range(0, 400)) - 200;
    end
    repeat (2) @(posedge ps_clk);
    #1;
    capture_reset = 1'b1;
    assert (!readout_o.valid) else report_mismatch("readout valid after reset");
    assert (write_count_o == '0) else report_mismatch("write count not zero after reset");
    assert (state_o == idle) else report_mismatch("capture state not idle after reset");
    assert (!buffer_full_o) else report_mismatch("buffer full after reset");
    quiet = 1'b0;

    // zero hold with raw2 diff0 raw3 diff1
    set_mux({3'd5, 3'd3, 3'd4, 3'd2});
    run(8);
    arm_i = 1'b1;
    run(21);
    // masked off line must not start the capture
    trig_i = 2'b10;
    run(3);
    trig_i = '0;
    assert (state_o == armed) else report_mismatch("masked trigger line started capture");
    fire_trigger();
    run(40);
    end_capture();
    read_all();

    // hold of 3 with raw1 diff2 raw0 diff3
    set_mux({3'd7, 3'd0, 3'd6, 3'd1});
    hold_i = 4'd3;
    clear_and_arm();
    fire_trigger();
    run(40);
    end_capture();
    read_all();

    // sw reset in mid capture during a quiet stretch
    clear_and_arm();
    fire_trigger();
    run(30);
    quiet = 1'b1;
    run(10);
    assert (write_count_o != '0) else report_mismatch("nothing stored before sw reset");
    capture_sw_reset_i = 1'b1;
    exp_q.delete();
    in_window = 1'b0;
    run(1);
    assert (write_count_o == '0) else report_mismatch("count not cleared by sw reset");
    assert (state_o == idle) else report_mismatch("state not idle after sw reset");
    run(10);
    assert (write_count_o == '0) else report_mismatch("count moved after sw reset");
    // start with nothing stored is ignored
    rd_total        = 0;
    rd_idx          = 0;
    readout_start_i = 1'b1;
    run(4);
    arm_i = 1'b1;
    run(1);
    fire_trigger();
    run(150);
    end_capture();
    assert (exp_q.size() > buffer_depth) else report_mismatch("too few kept frames to fill");
    assert (buffer_full_o) else report_mismatch("buffer full flag not set");

    // abort after a few beats and read everything again
    start_readout();
    wait_beats(5);
    readout_sw_reset_i = 1'b1;
    run(1);
    assert (!readout_o.valid) else report_mismatch("readout valid after readout sw reset");
    aborted_at = rd_idx;
    run(4);
    assert (rd_idx == aborted_at) else report_mismatch("beats continued after abort");
    read_all();

    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
